/* bench/tb_lsu.sv */
`timescale 1ns/1ps
`include "lsu_defines.svh"

module tb_lsu
    import lsu_pkg::*;
();

    localparam int WAIT_LIMIT = 1000;    // cycles before a wait gives up

    typedef struct packed {
        logic                   we;
        logic [4:0]             rd;
        logic [`LSU_DATA_W-1:0] wdata;
        logic                   chk_data;    // result data is defined
        logic                   ale;
        logic [`LSU_SEQ_W-1:0]  seq;
    } exp_rec_t;

    logic                   clk;
    logic                   resetn;
    logic                   op_valid;
    mem_op_e                op_code;
    logic [`LSU_ADDR_W-1:0] op_addr;
    logic [`LSU_DATA_W-1:0] op_wdata;
    logic [4:0]             op_rd;
    logic                   op_allowin;
    logic                   retire_ready;
    logic                   retire_valid;
    logic                   retire_we;
    logic [4:0]             retire_rd;
    logic [`LSU_DATA_W-1:0] retire_wdata;
    logic                   retire_ale;
    logic [`LSU_SEQ_W-1:0]  retire_seq;

    logic [7:0]            ref_mem [0:(1<<`LSU_ADDR_W)-1];    // byte image of the RAM
    exp_rec_t              exp_q[$];
    logic [`LSU_SEQ_W-1:0] next_seq;
    logic                  bp_mode;
    int                    checks;
    int                    errors;
    int                    checks_at_start;
    int                    errors_at_start;
    int unsigned           seed_val;

    lsu_top dut (
        .clk          (clk),
        .resetn       (resetn),
        .op_valid     (op_valid),
        .op_code      (op_code),
        .op_addr      (op_addr),
        .op_wdata     (op_wdata),
        .op_rd        (op_rd),
        .op_allowin   (op_allowin),
        .retire_ready (retire_ready),
        .retire_valid (retire_valid),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_wdata (retire_wdata),
        .retire_ale   (retire_ale),
        .retire_seq   (retire_seq)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // expected retire record from the reference memory before this op's store lands
    function automatic exp_rec_t expect_result(input mem_op_e op,
                                               input logic [`LSU_ADDR_W-1:0] addr,
                                               input logic [`LSU_DATA_W-1:0] wdata,
                                               input logic [4:0] rd);
        exp_rec_t               r;
        int                     size;
        logic [`LSU_ADDR_W-1:0] base;
        logic [`LSU_DATA_W-1:0] word;
        logic [7:0]             bval;
        logic [15:0]            half;
        base = {addr[`LSU_ADDR_W-1:2], 2'b00};
        word = {ref_mem[base + 10'd3], ref_mem[base + 10'd2],
                ref_mem[base + 10'd1], ref_mem[base]};
        bval = ref_mem[addr];
        half = {ref_mem[{addr[`LSU_ADDR_W-1:1], 1'b1}],
                ref_mem[{addr[`LSU_ADDR_W-1:1], 1'b0}]};    // little endian
        case (op)
            op_ld_h, op_ld_hu, op_st_h: size = 2;
            op_ld_w, op_st_w:           size = 4;
            default:                    size = 1;
        endcase
        r     = '0;
        r.rd  = rd;
        r.ale = (int'(addr) % size) != 0;    // access must sit on its own size
        r.we       = 1'b1;
        r.chk_data = 1'b1;
        case (op)
            op_li:    r.wdata = wdata;
            op_ld_b:  r.wdata = {{24{bval[7]}}, bval};
            op_ld_bu: r.wdata = {24'h0, bval};
            op_ld_h:  r.wdata = {{16{half[15]}}, half};
            op_ld_hu: r.wdata = {16'h0, half};
            op_ld_w:  r.wdata = word;
            default: begin
                r.we       = 1'b0;    // stores
                r.chk_data = 1'b0;
            end
        endcase
        if (r.ale) begin
            r.we       = 1'b0;
            r.chk_data = 1'b0;
        end
        if (rd == 5'd0) begin
            r.we = 1'b0;
        end
        return r;
    endfunction

    task automatic apply_store(input mem_op_e op, input logic [`LSU_ADDR_W-1:0] addr,
                               input logic [`LSU_DATA_W-1:0] wdata);
        if (op == op_st_b) begin
            ref_mem[addr] = wdata[7:0];
        end else if (op == op_st_h && !addr[0]) begin
            ref_mem[addr]         = wdata[7:0];
            ref_mem[addr + 10'd1] = wdata[15:8];
        end else if (op == op_st_w && addr[1:0] == 2'b00) begin
            for (int i = 0; i < 4; i++) begin
                ref_mem[addr + 10'(i)] = wdata[8*i +: 8];
            end
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    // called and returns at posedge + 1
    task automatic issue_op(input mem_op_e op, input logic [`LSU_ADDR_W-1:0] addr,
                            input logic [`LSU_DATA_W-1:0] wdata, input logic [4:0] rd);
        exp_rec_t r;
        int       waited;
        r        = expect_result(op, addr, wdata, rd);
        r.seq    = next_seq;
        op_valid = 1'b1;
        op_code  = op;
        op_addr  = addr;
        op_wdata = wdata;
        op_rd    = rd;
        waited   = 0;
        @(negedge clk);
        while (!op_allowin) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("timeout: the DUT never accepted an operation");
            end
            @(negedge clk);
        end
        exp_q.push_back(r);
        apply_store(op, addr, wdata);
        next_seq = next_seq + 1'b1;
        @(posedge clk);
        #1;
        op_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic drain_pipeline();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("timeout: expected results never retired");
            end
            @(posedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input int num, input string name);
        $display("test %0d %s: %0d checks, %0d errors", num, name,
                 checks - checks_at_start, errors - errors_at_start);
        checks_at_start = checks;
        errors_at_start = errors;
    endtask

    task automatic report_mismatch(input string name, input logic [`LSU_DATA_W-1:0] exp_val,
                                   input logic [`LSU_DATA_W-1:0] got_val);
        $display("** Error at %0t: %s expected %h, got %h", $time, name, exp_val, got_val);
        errors++;
    endtask

    initial begin
        retire_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            retire_ready = bp_mode ? 1'($urandom_range(0, 1)) : 1'b1;
        end
    end

    // every retire transfer is checked against the oldest expected record
    initial begin
        exp_rec_t e;
        forever begin
            @(negedge clk);
            if (retire_valid && retire_ready) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected retire of seq %0d with nothing in flight", retire_seq);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    checks++;
                    if (retire_seq !== e.seq) begin
                        report_mismatch("retire_seq", 32'(e.seq), 32'(retire_seq));
                    end
                    if (retire_we !== e.we) begin
                        report_mismatch("retire_we", 32'(e.we), 32'(retire_we));
                    end
                    if (retire_rd !== e.rd) begin
                        report_mismatch("retire_rd", 32'(e.rd), 32'(retire_rd));
                    end
                    if (retire_ale !== e.ale) begin
                        report_mismatch("retire_ale", 32'(e.ale), 32'(retire_ale));
                    end
                    if (e.chk_data && retire_wdata !== e.wdata) begin
                        report_mismatch("retire_wdata", e.wdata, retire_wdata);
                    end
                end
            end
        end
    end

    initial begin
        seed_val        = $urandom(32'hec63d7cb);
        resetn          = 1'b0;
        op_valid        = 1'b0;
        op_code         = op_li;
        op_addr         = '0;
        op_wdata        = '0;
        op_rd           = '0;
        bp_mode         = 1'b0;
        next_seq        = '0;
        checks          = 0;
        errors          = 0;
        checks_at_start = 0;
        errors_at_start = 0;
        repeat (16) begin
            @(posedge clk);
        end
        #1;
        resetn = 1'b1;
        idle_cycles(2);

        for (int i = 0; i < 16; i++) begin
            issue_op(op_st_w, 10'(i * 4), $urandom, 5'($urandom_range(0, 31)));
        end
        for (int i = 0; i < 16; i++) begin
            issue_op(op_ld_w, 10'(i * 4), 32'h0, 5'($urandom_range(1, 31)));
        end
        drain_pipeline();
        finish_test(1, "word round trip");

        issue_op(op_st_w, 10'(16 * 4), 32'hf08e_c1a7, 5'd1);    // every byte negative
        issue_op(op_st_w, 10'(17 * 4), 32'h7f80_ff01, 5'd1);
        for (int w = 16; w < 18; w++) begin
            for (int off = 0; off < 4; off++) begin
                issue_op(op_ld_b, 10'(w * 4 + off), 32'h0, 5'($urandom_range(1, 31)));
                issue_op(op_ld_bu, 10'(w * 4 + off), 32'h0, 5'($urandom_range(1, 31)));
            end
            for (int off = 0; off < 4; off += 2) begin
                issue_op(op_ld_h, 10'(w * 4 + off), 32'h0, 5'($urandom_range(1, 31)));
                issue_op(op_ld_hu, 10'(w * 4 + off), 32'h0, 5'($urandom_range(1, 31)));
            end
        end
        drain_pipeline();
        finish_test(2, "sub-word loads");

        issue_op(op_st_w, 10'(18 * 4), 32'h1234_5678, 5'd2);
        for (int off = 0; off < 4; off++) begin
            issue_op(op_st_b, 10'(18 * 4 + off), $urandom, 5'd2);
            issue_op(op_ld_w, 10'(18 * 4), 32'h0, 5'd3);
        end
        issue_op(op_st_h, 10'(18 * 4 + 2), $urandom, 5'd2);
        issue_op(op_ld_w, 10'(18 * 4), 32'h0, 5'd4);
        issue_op(op_st_h, 10'(18 * 4), $urandom, 5'd2);
        issue_op(op_ld_w, 10'(18 * 4), 32'h0, 5'd5);
        drain_pipeline();
        finish_test(3, "sub-word stores");

        issue_op(op_st_w, 10'(19 * 4), 32'hcafe_f00d, 5'd6);
        issue_op(op_st_h, 10'(19 * 4 + 1), 32'h1111_1111, 5'd6);
        issue_op(op_st_h, 10'(19 * 4 + 3), 32'h2222_2222, 5'd6);
        issue_op(op_st_w, 10'(19 * 4 + 2), 32'h3333_3333, 5'd6);
        issue_op(op_st_w, 10'(19 * 4 + 1), 32'h4444_4444, 5'd6);
        issue_op(op_ld_h, 10'(19 * 4 + 1), 32'h0, 5'd7);
        issue_op(op_ld_hu, 10'(19 * 4 + 3), 32'h0, 5'd7);
        issue_op(op_ld_w, 10'(19 * 4 + 2), 32'h0, 5'd7);
        issue_op(op_ld_w, 10'(19 * 4), 32'h0, 5'd8);    // must still read the old word
        drain_pipeline();
        finish_test(4, "alignment errors");

        bp_mode = 1'b1;
        for (int i = 0; i < 200; i++) begin
            if ($urandom_range(0, 3) == 0) begin
                idle_cycles(int'($urandom_range(1, 3)));
            end
            issue_op(mem_op_e'($urandom_range(0, 8)),
                     10'($urandom_range(0, 19) * 4 + $urandom_range(0, 3)),
                     $urandom, 5'($urandom_range(0, 31)));
        end
        drain_pipeline();
        bp_mode = 1'b0;
        idle_cycles(2);
        finish_test(5, "back-pressure");

        for (int i = 0; i < 12; i++) begin
            issue_op(op_li, 10'($urandom_range(0, 1023)), $urandom,
                     (i % 3 == 0) ? 5'd0 : 5'($urandom_range(1, 31)));
        end
        drain_pipeline();
        finish_test(6, "op_li");

        $display("all tests done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* design/data_ram.sv */
`timescale 1ns/1ps
`include "lsu_defines.svh"

module data_ram (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     ram_req,
    input  logic                     ram_wr,
    input  logic [`LSU_DATA_W/8-1:0] ram_strb,
    input  logic [`LSU_ADDR_W-1:0]   ram_addr,
    input  logic [`LSU_DATA_W-1:0]   ram_wdata,
    output logic                     ram_data_ok,
    output logic [`LSU_DATA_W-1:0]   ram_rdata
);

    localparam int IDX_W = $clog2(`LSU_RAM_WORDS);

    logic [`LSU_DATA_W-1:0] mem [0:`LSU_RAM_WORDS-1];
    logic [IDX_W-1:0]       idx;

    assign idx = ram_addr[IDX_W+1:2];    // word index without the byte bits

    always_ff @(posedge clk) begin
        if (ram_req) begin
            ram_rdata <= mem[idx];    // old word even on a write
            if (ram_wr) begin
                for (int i = 0; i < `LSU_DATA_W/8; i++) begin
                    if (ram_strb[i]) begin
                        mem[idx][8*i +: 8] <= ram_wdata[8*i +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ram_data_ok <= 1'b0;
        end else begin
            ram_data_ok <= ram_req;    // one cycle answer
        end
    end

    // a write always carries a strobe and a read never does
    a_strb_matches_wr: assert property (@(posedge clk) disable iff (!resetn)
        ram_req |-> ram_wr == (ram_strb != '0));

endmodule

/* design/ex_stage.sv */
`timescale 1ns/1ps
`include "lsu_defines.svh"

module ex_stage
    import lsu_pkg::*;
(
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     op_valid,
    input  mem_op_e                  op_code,
    input  logic [`LSU_ADDR_W-1:0]   op_addr,
    input  logic [`LSU_DATA_W-1:0]   op_wdata,
    input  logic [4:0]               op_rd,
    output logic                     op_allowin,
    stage_if.sender                  out,
    output logic                     ram_req,
    output logic                     ram_wr,
    output logic [`LSU_DATA_W/8-1:0] ram_strb,
    output logic [`LSU_ADDR_W-1:0]   ram_addr,
    output logic [`LSU_DATA_W-1:0]   ram_wdata
);

    logic                   ex_valid;
    mem_op_e                ex_op;
    logic [`LSU_ADDR_W-1:0] ex_addr;
    logic [`LSU_DATA_W-1:0] ex_wdata;
    logic [4:0]             ex_rd;
    logic [`LSU_SEQ_W-1:0]  ex_seq;
    logic [`LSU_SEQ_W-1:0]  seq_cnt;
    logic                   is_mem;
    logic                   is_store;
    logic                   ex_ale;

    assign op_allowin = ~ex_valid | out.allowin;    // ex is always ready to go

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
            seq_cnt  <= '0;
        end else if (op_allowin) begin
            ex_valid <= op_valid;
            if (op_valid) begin
                seq_cnt <= seq_cnt + 1'b1;    // one tag per accepted op
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid && op_allowin) begin
            ex_op    <= op_code;
            ex_addr  <= op_addr;
            ex_wdata <= op_wdata;
            ex_rd    <= op_rd;
            ex_seq   <= seq_cnt;
        end
    end

    assign is_mem   = (ex_op != op_li);
    assign is_store = ex_op inside {op_st_b, op_st_h, op_st_w};

    always_comb begin
        case (ex_op)
            op_ld_h, op_ld_hu, op_st_h: ex_ale = ex_addr[0];
            op_ld_w, op_st_w:           ex_ale = |ex_addr[1:0];
            default:                    ex_ale = 1'b0;    // bytes never misalign
        endcase
    end

    // store data copied into every lane and the strobe picks the live one
    always_comb begin
        case (ex_op)
            op_st_b: begin
                ram_strb  = 4'b0001 << ex_addr[1:0];
                ram_wdata = {4{ex_wdata[7:0]}};
            end
            op_st_h: begin
                ram_strb  = ex_addr[1] ? 4'b1100 : 4'b0011;
                ram_wdata = {2{ex_wdata[15:0]}};
            end
            op_st_w: begin
                ram_strb  = 4'b1111;
                ram_wdata = ex_wdata;
            end
            default: begin
                ram_strb  = 4'b0000;    // loads write nothing
                ram_wdata = ex_wdata;
            end
        endcase
    end

    assign ram_req  = ex_valid & out.allowin & is_mem & ~ex_ale;    // only on the transfer
    assign ram_wr   = is_store;
    assign ram_addr = ex_addr;

    assign out.valid   = ex_valid;
    assign out.payload = '{op:     ex_op,
                           rd:     ex_rd,
                           offset: ex_addr[1:0],
                           wdata:  ex_wdata,
                           ale:    ex_ale,
                           seq:    ex_seq};

    // each op asks the RAM at most once
    a_one_req_per_op: assert property (@(posedge clk) disable iff (!resetn)
        ram_req |=> !ram_req || ex_seq != $past(ex_seq));

endmodule

/* design/lsu_defines.svh */
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

`define LSU_DATA_W    32     // data path width
`define LSU_ADDR_W    10     // byte address width
`define LSU_RAM_WORDS 256    // data RAM depth in words
`define LSU_SEQ_W     8      // retire sequence tag width

`endif

/* design/lsu_pkg.sv */
package lsu_pkg;

    `include "lsu_defines.svh"

    // memory opcodes where op_li stands for every non-memory result
    typedef enum logic [3:0] {
        op_li,
        op_ld_b,
        op_ld_bu,
        op_ld_h,
        op_ld_hu,
        op_ld_w,
        op_st_b,
        op_st_h,
        op_st_w
    } mem_op_e;

    typedef struct packed {
        mem_op_e                op;        // operation
        logic [4:0]             rd;        // destination register
        logic [1:0]             offset;    // byte offset in word
        logic [`LSU_DATA_W-1:0] wdata;     // op_li result
        logic                   ale;       // address alignment error
        logic [`LSU_SEQ_W-1:0]  seq;       // sequence tag
    } ex_mem_payload_t;

    typedef struct packed {
        logic                   we;        // register write enable
        logic [4:0]             rd;        // destination register
        logic [`LSU_DATA_W-1:0] wdata;     // result data
        logic                   ale;       // address alignment error
        logic [`LSU_SEQ_W-1:0]  seq;       // sequence tag
    } mem_wb_payload_t;

endpackage

/* design/lsu_top.sv */
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_top
    import lsu_pkg::*;
(
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   op_valid,
    input  mem_op_e                op_code,
    input  logic [`LSU_ADDR_W-1:0] op_addr,
    input  logic [`LSU_DATA_W-1:0] op_wdata,
    input  logic [4:0]             op_rd,
    output logic                   op_allowin,
    input  logic                   retire_ready,
    output logic                   retire_valid,
    output logic                   retire_we,
    output logic [4:0]             retire_rd,
    output logic [`LSU_DATA_W-1:0] retire_wdata,
    output logic                   retire_ale,
    output logic [`LSU_SEQ_W-1:0]  retire_seq
);

    logic                     ram_req;
    logic                     ram_wr;
    logic [`LSU_DATA_W/8-1:0] ram_strb;
    logic [`LSU_ADDR_W-1:0]   ram_addr;
    logic [`LSU_DATA_W-1:0]   ram_wdata;
    logic                     ram_data_ok;
    logic [`LSU_DATA_W-1:0]   ram_rdata;

    stage_if #(.payload_t(ex_mem_payload_t)) ex_to_mem ();
    stage_if #(.payload_t(mem_wb_payload_t)) mem_to_wb ();

    ex_stage u_ex (
        .clk        (clk),
        .resetn     (resetn),
        .op_valid   (op_valid),
        .op_code    (op_code),
        .op_addr    (op_addr),
        .op_wdata   (op_wdata),
        .op_rd      (op_rd),
        .op_allowin (op_allowin),
        .out        (ex_to_mem),
        .ram_req    (ram_req),
        .ram_wr     (ram_wr),
        .ram_strb   (ram_strb),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata)
    );

    data_ram u_ram (
        .clk         (clk),
        .resetn      (resetn),
        .ram_req     (ram_req),
        .ram_wr      (ram_wr),
        .ram_strb    (ram_strb),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .ram_data_ok (ram_data_ok),
        .ram_rdata   (ram_rdata)
    );

    mem_stage u_mem (
        .clk         (clk),
        .resetn      (resetn),
        .in          (ex_to_mem),
        .out         (mem_to_wb),
        .ram_data_ok (ram_data_ok),
        .ram_rdata   (ram_rdata)
    );

    wb_stage u_wb (
        .clk          (clk),
        .resetn       (resetn),
        .in           (mem_to_wb),
        .retire_ready (retire_ready),
        .retire_valid (retire_valid),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_wdata (retire_wdata),
        .retire_ale   (retire_ale),
        .retire_seq   (retire_seq)
    );

endmodule

/* design/mem_stage.sv */
`timescale 1ns/1ps
`include "lsu_defines.svh"

module mem_stage
    import lsu_pkg::*;
(
    input  logic                   clk,
    input  logic                   resetn,
    stage_if.receiver              in,
    stage_if.sender                out,
    input  logic                   ram_data_ok,
    input  logic [`LSU_DATA_W-1:0] ram_rdata
);

    typedef enum logic [1:0] {
        mem_idle,         // empty or nothing asked of the RAM
        mem_wait,         // request out, answer due
        mem_have_data     // answer held in hold_rdata
    } mem_state_e;

    mem_state_e             state;
    logic                   mem_valid;
    logic                   ready_go;
    ex_mem_payload_t        pl;
    logic [`LSU_DATA_W-1:0] hold_rdata;
    logic [`LSU_DATA_W-1:0] rdata;
    logic [7:0]             byte_val;
    logic [15:0]            half_val;
    logic                   res_we;
    logic [`LSU_DATA_W-1:0] res_wdata;

    assign ready_go   = (state != mem_wait) | ram_data_ok;
    assign in.allowin = ~mem_valid | (ready_go & out.allowin);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
            state     <= mem_idle;
        end else if (in.allowin) begin
            mem_valid <= in.valid;
            // ex issued a request exactly when the op is a memory op without ale
            if (in.valid && in.payload.op != op_li && !in.payload.ale) begin
                state <= mem_wait;
            end else begin
                state <= mem_idle;
            end
        end else if (state == mem_wait && ram_data_ok) begin
            state <= mem_have_data;    // wb stalled so keep the answer
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.allowin) begin
            pl <= in.payload;
        end
        if (state == mem_wait && ram_data_ok) begin
            hold_rdata <= ram_rdata;
        end
    end

    assign rdata    = (state == mem_have_data) ? hold_rdata : ram_rdata;
    assign byte_val = rdata[8*pl.offset +: 8];
    assign half_val = pl.offset[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        res_we    = 1'b1;
        res_wdata = '0;
        case (pl.op)
            op_li:    res_wdata = pl.wdata;
            op_ld_b:  res_wdata = {{24{byte_val[7]}}, byte_val};
            op_ld_bu: res_wdata = {24'b0, byte_val};
            op_ld_h:  res_wdata = {{16{half_val[15]}}, half_val};
            op_ld_hu: res_wdata = {16'b0, half_val};
            op_ld_w:  res_wdata = rdata;
            default:  res_we    = 1'b0;    // stores write no register
        endcase
        if (pl.ale) begin
            res_we    = 1'b0;
            res_wdata = '0;
        end
    end

    assign out.valid   = mem_valid & ready_go;
    assign out.payload = '{we:    res_we,
                           rd:    pl.rd,
                           wdata: res_wdata,
                           ale:   pl.ale,
                           seq:   pl.seq};

    // an answer must belong to the op that just entered mem
    a_ok_while_waiting: assert property (@(posedge clk) disable iff (!resetn)
        ram_data_ok |-> state == mem_wait);

endmodule

/* design/stage_if.sv */
`timescale 1ns/1ps

// valid/allowin link between two pipeline stages
interface stage_if #(
    parameter type payload_t = logic
) ();

    logic     valid;      // sender holds work
    logic     allowin;    // receiver can take it
    payload_t payload;

    modport sender (
        output valid,
        output payload,
        input  allowin
    );

    modport receiver (
        input  valid,
        input  payload,
        output allowin
    );

endinterface

/* design/wb_stage.sv */
`timescale 1ns/1ps
`include "lsu_defines.svh"

module wb_stage
    import lsu_pkg::*;
(
    input  logic                   clk,
    input  logic                   resetn,
    stage_if.receiver              in,
    input  logic                   retire_ready,
    output logic                   retire_valid,
    output logic                   retire_we,
    output logic [4:0]             retire_rd,
    output logic [`LSU_DATA_W-1:0] retire_wdata,
    output logic                   retire_ale,
    output logic [`LSU_SEQ_W-1:0]  retire_seq
);

    logic            wb_valid;
    mem_wb_payload_t wb_rec;

    assign in.allowin = ~wb_valid | retire_ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (in.allowin) begin
            wb_valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.allowin) begin
            wb_rec <= in.payload;
        end
    end

    assign retire_valid = wb_valid;
    assign retire_we    = wb_valid & wb_rec.we & (wb_rec.rd != 5'd0);    // r0 is never written
    assign retire_rd    = wb_rec.rd;
    assign retire_wdata = wb_rec.wdata;
    assign retire_ale   = wb_rec.ale;
    assign retire_seq   = wb_rec.seq;

    // back to back retires carry consecutive tags
    a_seq_in_order: assert property (@(posedge clk) disable iff (!resetn)
        retire_valid && retire_ready |=>
            !retire_valid || retire_seq == $past(retire_seq) + 1'b1);

endmodule

/* files.f */
+incdir+design
design/lsu_pkg.sv
design/stage_if.sv
design/ex_stage.sv
design/data_ram.sv
design/mem_stage.sv
design/wb_stage.sv
design/lsu_top.sv
bench/tb_lsu.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_lsu -f files.f -o tb_lsu
./obj_dir/tb_lsu > sim.log
cat sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    exit 0
else
    exit 1
fi
